/* hw/ifetch_pkg.sv */
// Instruction fetch front end: shared constants, vector types, handshake payloads
package ifetch_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Geometry and reset values
   ////////////////////////////////////////////////////////////////////////////

   // Page offset width, 8 KiB pages
   localparam int PAGE_SHIFT = 13;
   // 64-set direct-mapped TLB
   localparam int TLB_SETS_LOG2 = 6;
   // Instruction image depth in words
   localparam int IMAGE_WORDS_LOG2 = 5;

   // Flag positions within a TLB entry
   localparam int TLBL_V_BIT = 0;
   localparam int TLBH_UX_BIT = 3;
   localparam int TLBH_RX_BIT = 4;

   ////////////////////////////////////////////////////////////////////////////
   // Vector types
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [31:0] vaddr_t;
   typedef logic [31:0] paddr_t;
   typedef logic [31:0] insn_t;
   typedef logic [31:0] tlb_word_t;
   typedef logic [TLB_SETS_LOG2-1:0] tlb_idx_t;
   // Page numbers, address bits 31..13
   typedef logic [31-PAGE_SHIFT:0] vpn_t;
   typedef logic [31-PAGE_SHIFT:0] ppn_t;

   // First fetch address out of reset
   localparam vaddr_t RESET_PC = 32'h0000_0000;

   ////////////////////////////////////////////////////////////////////////////
   // Payloads and control words
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic imme;          // translation on
      logic rm;            // supervisor mode
   } psr_t;

   // Software TLB access, sel_hi picks the high word
   typedef struct packed {
      tlb_idx_t  idx;
      logic      sel_hi;
      logic      we;
      tlb_word_t wdata;
   } tlb_acc_t;

   typedef struct packed {
      vaddr_t vaddr;
   } fetch_cmd_t;

   // vaddr and flags ride along as sideband
   typedef struct packed {
      paddr_t paddr;
      vaddr_t vaddr;
      logic   tlb_miss;
      logic   page_fault;
   } mem_cmd_t;

   typedef struct packed {
      insn_t  insn;
      vaddr_t vaddr;
      logic   tlb_miss;
      logic   page_fault;
   } fetch_rsp_t;

   // Fetch address generator FSM
   typedef enum logic [1:0] {
      FAG_IDLE,
      FAG_RUN,
      FAG_REDIRECT
   } fag_state_t;

endpackage

/* hw/fetch_addr_gen.sv */
// Fetch address generator: sequential PC stream, redirected by flush
`timescale 1ns/10ps

module fetch_addr_gen (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   fetch_en,
   input  logic                   flush_req,
   input  ifetch_pkg::vaddr_t     flush_addr,
   output logic                   cmd_valid,
   input  logic                   cmd_ready,
   output ifetch_pkg::fetch_cmd_t cmd
);

   ifetch_pkg::fag_state_t state;
   ifetch_pkg::fag_state_t state_nxt;
   ifetch_pkg::vaddr_t     pc;
   logic                   cmd_hds;

   // Valid in any state but idle
   assign cmd_valid = (state != ifetch_pkg::FAG_IDLE);
   assign cmd_hds = cmd_valid & cmd_ready;
   // Flush target overrides the sequential PC
   assign cmd.vaddr = flush_req ? flush_addr : pc;

   always_comb begin
      state_nxt = state;
      unique case (state)
         ifetch_pkg::FAG_IDLE: begin
            // Flush must issue even when fetching is off
            if (flush_req)
               state_nxt = ifetch_pkg::FAG_REDIRECT;
            else if (fetch_en)
               state_nxt = ifetch_pkg::FAG_RUN;
         end
         ifetch_pkg::FAG_RUN: begin
            if (cmd_hds)
               state_nxt = fetch_en ? ifetch_pkg::FAG_RUN : ifetch_pkg::FAG_IDLE;
            else if (flush_req)
               state_nxt = ifetch_pkg::FAG_REDIRECT;
         end
         ifetch_pkg::FAG_REDIRECT: begin
            // Hold until the flush command is taken
            if (cmd_hds)
               state_nxt = fetch_en ? ifetch_pkg::FAG_RUN : ifetch_pkg::FAG_IDLE;
         end
         default: state_nxt = ifetch_pkg::FAG_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ifetch_pkg::FAG_IDLE;
         pc    <= ifetch_pkg::RESET_PC;
      end else begin
         state <= state_nxt;
         // Next sequential word after whatever was issued
         if (cmd_hds)
            pc <= cmd.vaddr + 32'd4;
      end
   end

endmodule

/* hw/immu_tlb.sv */
// Instruction TLB storage: registered lookup port plus software access port
`timescale 1ns/10ps

module immu_tlb (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  lookup_en,
   input  ifetch_pkg::tlb_idx_t  lookup_idx,
   output ifetch_pkg::tlb_word_t lookup_lo,
   output ifetch_pkg::tlb_word_t lookup_hi,
   input  ifetch_pkg::tlb_acc_t  tlb_acc,
   output ifetch_pkg::tlb_word_t tlb_rdata
);

   localparam int NSETS = 2 ** ifetch_pkg::TLB_SETS_LOG2;

   // Low words hold VPN and valid, high words PPN and permissions
   ifetch_pkg::tlb_word_t tlb_lo [NSETS];
   ifetch_pkg::tlb_word_t tlb_hi [NSETS];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // All entries invalid out of reset
         tlb_lo    <= '{default: '0};
         tlb_hi    <= '{default: '0};
         lookup_lo <= '0;
         lookup_hi <= '0;
         tlb_rdata <= '0;
      end else begin
         // Lookup read, held between requests
         if (lookup_en) begin
            lookup_lo <= tlb_lo[lookup_idx];
            lookup_hi <= tlb_hi[lookup_idx];
         end
         // Software read, old contents on a same-cycle write
         tlb_rdata <= tlb_acc.sel_hi ? tlb_hi[tlb_acc.idx] : tlb_lo[tlb_acc.idx];
         // Software write
         if (tlb_acc.we) begin
            if (tlb_acc.sel_hi)
               tlb_hi[tlb_acc.idx] <= tlb_acc.wdata;
            else
               tlb_lo[tlb_acc.idx] <= tlb_acc.wdata;
         end
      end
   end

endmodule

/* hw/immu.sv */
// Instruction MMU stage: TLB translation, execute check, flush cancel, output slot
`timescale 1ns/10ps

module immu (
   input  logic                  clk,
   input  logic                  rst_n,
   input  ifetch_pkg::psr_t      psr,
   input  logic                  flush_req,
   output logic                  flush_ack,
   input  logic                  cmd_valid,
   output logic                  cmd_ready,
   input  ifetch_pkg::fetch_cmd_t cmd,
   output logic                  lookup_en,
   output ifetch_pkg::tlb_idx_t  lookup_idx,
   input  ifetch_pkg::tlb_word_t lookup_lo,
   input  ifetch_pkg::tlb_word_t lookup_hi,
   output logic                  mem_cmd_valid,
   input  logic                  mem_cmd_ready,
   output ifetch_pkg::mem_cmd_t  mem_cmd
);

   logic               slot_valid;
   logic               cmd_hds;
   logic               mem_hds;
   ifetch_pkg::vaddr_t vaddr_q;
   ifetch_pkg::psr_t   psr_q;

   // Fields of the held address
   ifetch_pkg::vpn_t                  tgt_vpn;
   logic [ifetch_pkg::PAGE_SHIFT-1:0] tgt_offset;

   // Fields of the looked-up entry
   logic             tlb_v;
   logic             tlb_ux;
   logic             tlb_rx;
   ifetch_pkg::vpn_t tlb_vpn;
   ifetch_pkg::ppn_t tlb_ppn;
   logic             perm_denied;
   logic             tlb_hit;

   ////////////////////////////////////////////////////////////////////////////
   // Handshakes and flush
   ////////////////////////////////////////////////////////////////////////////

   // Slot frees on hand-off, or is discarded by a flush
   assign cmd_ready = ~slot_valid | mem_cmd_ready | flush_req;
   assign cmd_hds = cmd_valid & cmd_ready;
   // Nothing leaves toward memory while a flush is pending
   assign mem_cmd_valid = slot_valid & ~flush_req;
   assign mem_hds = mem_cmd_valid & mem_cmd_ready;
   // Flush completes when its target enters the slot
   assign flush_ack = flush_req & cmd_hds;

   // TLB read started on acceptance, index from low VPN bits
   assign lookup_en = cmd_hds;
   assign lookup_idx = cmd.vaddr[ifetch_pkg::PAGE_SHIFT +: ifetch_pkg::TLB_SETS_LOG2];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         slot_valid <= 1'b0;
      else if (cmd_hds)
         slot_valid <= 1'b1;
      else if (mem_hds || flush_req)
         slot_valid <= 1'b0;
   end

   // Address and mode sampled with the command
   always_ff @(posedge clk) begin
      if (cmd_hds) begin
         vaddr_q <= cmd.vaddr;
         psr_q   <= psr;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Translation
   ////////////////////////////////////////////////////////////////////////////

   assign tgt_vpn    = vaddr_q[31:ifetch_pkg::PAGE_SHIFT];
   assign tgt_offset = vaddr_q[ifetch_pkg::PAGE_SHIFT-1:0];

   assign tlb_v   = lookup_lo[ifetch_pkg::TLBL_V_BIT];
   assign tlb_vpn = lookup_lo[31:ifetch_pkg::PAGE_SHIFT];
   assign tlb_ux  = lookup_hi[ifetch_pkg::TLBH_UX_BIT];
   assign tlb_rx  = lookup_hi[ifetch_pkg::TLBH_RX_BIT];
   assign tlb_ppn = lookup_hi[31:ifetch_pkg::PAGE_SHIFT];

   // rx in supervisor mode, ux in user mode
   assign perm_denied = psr_q.rm ? ~tlb_rx : ~tlb_ux;
   assign tlb_hit = tlb_v & (tlb_vpn == tgt_vpn);

   always_comb begin
      mem_cmd.vaddr = vaddr_q;
      if (psr_q.imme) begin
         mem_cmd.paddr = {tlb_ppn, tgt_offset};
         // Fault takes priority, so the flags never overlap
         mem_cmd.page_fault = perm_denied;
         mem_cmd.tlb_miss   = ~perm_denied & ~tlb_hit;
      end else begin
         // Identity map when off
         mem_cmd.paddr      = vaddr_q;
         mem_cmd.page_fault = 1'b0;
         mem_cmd.tlb_miss   = 1'b0;
      end
   end

endmodule

/* hw/insn_mem.sv */
// Instruction memory: image ROM with a one-cycle registered response
`timescale 1ns/10ps

module insn_mem (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   cmd_valid,
   output logic                   cmd_ready,
   input  ifetch_pkg::mem_cmd_t   cmd,
   output logic                   rsp_valid,
   input  logic                   rsp_ready,
   output ifetch_pkg::fetch_rsp_t rsp
);

   localparam int NWORDS = 2 ** ifetch_pkg::IMAGE_WORDS_LOG2;

   ifetch_pkg::insn_t rom [NWORDS];
   logic              cmd_hds;

   initial begin
      $readmemh("bench/insn_image.hex", rom);
   end

   // Accept when the response register is empty or draining
   assign cmd_ready = ~rsp_valid | rsp_ready;
   assign cmd_hds = cmd_valid & cmd_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         rsp_valid <= 1'b0;
      else if (cmd_hds)
         rsp_valid <= 1'b1;
      else if (rsp_ready)
         rsp_valid <= 1'b0;
   end

   // Word select from paddr, flags and vaddr passed through
   always_ff @(posedge clk) begin
      if (cmd_hds) begin
         rsp.insn       <= rom[cmd.paddr[ifetch_pkg::IMAGE_WORDS_LOG2+1:2]];
         rsp.vaddr      <= cmd.vaddr;
         rsp.tlb_miss   <= cmd.tlb_miss;
         rsp.page_fault <= cmd.page_fault;
      end
   end

endmodule

/* hw/ifetch_top.sv */
// Instruction fetch front end: address generator, MMU, TLB and memory
`timescale 1ns/10ps

module ifetch_top (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   fetch_en,
   input  ifetch_pkg::psr_t       psr,
   input  logic                   flush_req,
   input  ifetch_pkg::vaddr_t     flush_addr,
   output logic                   flush_ack,
   input  ifetch_pkg::tlb_acc_t   tlb_acc,
   output ifetch_pkg::tlb_word_t  tlb_rdata,
   output logic                   rsp_valid,
   input  logic                   rsp_ready,
   output ifetch_pkg::fetch_rsp_t rsp
);

   // Generator to MMU
   logic                   fag_cmd_valid;
   logic                   fag_cmd_ready;
   ifetch_pkg::fetch_cmd_t fag_cmd;

   // MMU to memory
   logic                   mem_cmd_valid;
   logic                   mem_cmd_ready;
   ifetch_pkg::mem_cmd_t   mem_cmd;

   // MMU to TLB
   logic                   lookup_en;
   ifetch_pkg::tlb_idx_t   lookup_idx;
   ifetch_pkg::tlb_word_t  lookup_lo;
   ifetch_pkg::tlb_word_t  lookup_hi;

   fetch_addr_gen fetch_addr_gen_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .fetch_en   (fetch_en),
      .flush_req  (flush_req),
      .flush_addr (flush_addr),
      .cmd_valid  (fag_cmd_valid),
      .cmd_ready  (fag_cmd_ready),
      .cmd        (fag_cmd)
   );

   immu immu_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .psr           (psr),
      .flush_req     (flush_req),
      .flush_ack     (flush_ack),
      .cmd_valid     (fag_cmd_valid),
      .cmd_ready     (fag_cmd_ready),
      .cmd           (fag_cmd),
      .lookup_en     (lookup_en),
      .lookup_idx    (lookup_idx),
      .lookup_lo     (lookup_lo),
      .lookup_hi     (lookup_hi),
      .mem_cmd_valid (mem_cmd_valid),
      .mem_cmd_ready (mem_cmd_ready),
      .mem_cmd       (mem_cmd)
   );

   immu_tlb immu_tlb_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .lookup_en  (lookup_en),
      .lookup_idx (lookup_idx),
      .lookup_lo  (lookup_lo),
      .lookup_hi  (lookup_hi),
      .tlb_acc    (tlb_acc),
      .tlb_rdata  (tlb_rdata)
   );

   insn_mem insn_mem_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (mem_cmd_valid),
      .cmd_ready (mem_cmd_ready),
      .cmd       (mem_cmd),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp       (rsp)
   );

endmodule

/* bench/ifetch_properties.sv */
// Fetch front end protocol checks bound into the top level
`timescale 1ns/10ps

module ifetch_properties (
   input logic                   clk,
   input logic                   rst_n,
   input logic                   flush_req,
   input logic                   flush_ack,
   input logic                   cmd_valid,
   input logic                   cmd_ready,
   input ifetch_pkg::fetch_cmd_t cmd,
   input logic                   mem_cmd_valid,
   input logic                   mem_cmd_ready,
   input ifetch_pkg::mem_cmd_t   mem_cmd,
   input logic                   rsp_valid,
   input logic                   rsp_ready,
   input ifetch_pkg::fetch_rsp_t rsp
);

   // Count of failed assertions
   int fail_count = 0;

   ////////////////////////////////////////////////////////////////////////////
   // Valid/ready stability
   ////////////////////////////////////////////////////////////////////////////

   // A flush may retarget or cancel a stalled command
   assert property (@(posedge clk) disable iff (!rst_n)
      cmd_valid && !cmd_ready && !flush_req |=> flush_req || (cmd_valid && $stable(cmd)))
   else begin
      fail_count++;
      $error("Fetch command dropped or changed while stalled");
   end

   assert property (@(posedge clk) disable iff (!rst_n)
      mem_cmd_valid && !mem_cmd_ready && !flush_req |=>
         flush_req || (mem_cmd_valid && $stable(mem_cmd)))
   else begin
      fail_count++;
      $error("Memory command dropped or changed while stalled");
   end

   assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
   else begin
      fail_count++;
      $error("Response dropped or changed while stalled");
   end

   // Miss and fault never together
   assert property (@(posedge clk) disable iff (!rst_n)
      mem_cmd_valid |-> !(mem_cmd.tlb_miss && mem_cmd.page_fault))
   else begin
      fail_count++;
      $error("Memory command carries both miss and fault");
   end

   assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid |-> !(rsp.tlb_miss && rsp.page_fault))
   else begin
      fail_count++;
      $error("Response carries both miss and fault");
   end

   // Flush ack only under a request and for one cycle
   assert property (@(posedge clk) disable iff (!rst_n) flush_ack |-> flush_req)
   else begin
      fail_count++;
      $error("Flush ack without a flush request");
   end

   assert property (@(posedge clk) disable iff (!rst_n) flush_ack |=> !flush_ack)
   else begin
      fail_count++;
      $error("Flush ack longer than one cycle");
   end

   // Outputs quiet in reset
   assert property (@(posedge clk) !rst_n |-> !rsp_valid && !flush_ack)
   else begin
      fail_count++;
      $error("Response valid or flush ack during reset");
   end

endmodule

bind ifetch_top ifetch_properties ifetch_properties_i (
   .clk           (clk),
   .rst_n         (rst_n),
   .flush_req     (flush_req),
   .flush_ack     (flush_ack),
   .cmd_valid     (fag_cmd_valid),
   .cmd_ready     (fag_cmd_ready),
   .cmd           (fag_cmd),
   .mem_cmd_valid (mem_cmd_valid),
   .mem_cmd_ready (mem_cmd_ready),
   .mem_cmd       (mem_cmd),
   .rsp_valid     (rsp_valid),
   .rsp_ready     (rsp_ready),
   .rsp           (rsp)
);

/* bench/ifetch_tb.sv */
// Instruction fetch testbench with stimulus, response scoreboard, timeout and verdict
`timescale 1ns/10ps

module ifetch_tb;

   // Planned response counts per phase
   localparam int N_SEQ = 40;
   localparam int N_POST_FLUSH = 24;
   localparam int N_MAPPED = 20;
   localparam int N_SINGLE = 4;
   // Allowance for reset, TLB programming, drains and flush stalls
   localparam int SETUP_CYCLES = 200;
   localparam int MAX_CYCLES = 4 * (N_SEQ + N_POST_FLUSH + N_MAPPED + N_SINGLE) + SETUP_CYCLES;
   localparam int NSETS = 2 ** ifetch_pkg::TLB_SETS_LOG2;

   logic                   clk;
   logic                   rst_n;
   logic                   fetch_en;
   ifetch_pkg::psr_t       psr;
   logic                   flush_req;
   ifetch_pkg::vaddr_t     flush_addr;
   logic                   flush_ack;
   ifetch_pkg::tlb_acc_t   tlb_acc;
   ifetch_pkg::tlb_word_t  tlb_rdata;
   logic                   rsp_valid;
   logic                   rsp_ready;
   ifetch_pkg::fetch_rsp_t rsp;

   // Reference copies of the image and the TLB
   ifetch_pkg::insn_t     image [2 ** ifetch_pkg::IMAGE_WORDS_LOG2];
   ifetch_pkg::tlb_word_t model_lo [NSETS];
   ifetch_pkg::tlb_word_t model_hi [NSETS];

   logic [31:0]        lcg_state;
   logic               random_ready;
   int                 errors;
   int                 rsp_count;
   int                 cycles = 0;
   // Scoreboard state
   ifetch_pkg::vaddr_t exp_vaddr;
   ifetch_pkg::vaddr_t flush_target;
   logic               resync;
   int                 old_allowed;
   logic               ack_seen;

   ifetch_top ifetch_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Expected response from the translation rules
   function automatic ifetch_pkg::fetch_rsp_t expected_rsp(ifetch_pkg::vaddr_t va);
      ifetch_pkg::fetch_rsp_t p;
      ifetch_pkg::tlb_word_t  lo;
      ifetch_pkg::tlb_word_t  hi;
      ifetch_pkg::paddr_t     pa;
      lo = model_lo[va[ifetch_pkg::PAGE_SHIFT +: ifetch_pkg::TLB_SETS_LOG2]];
      hi = model_hi[va[ifetch_pkg::PAGE_SHIFT +: ifetch_pkg::TLB_SETS_LOG2]];
      p = '0;
      p.vaddr = va;
      pa = va;
      if (psr.imme) begin
         pa = {hi[31:ifetch_pkg::PAGE_SHIFT], va[ifetch_pkg::PAGE_SHIFT-1:0]};
         if (psr.rm ? !hi[ifetch_pkg::TLBH_RX_BIT] : !hi[ifetch_pkg::TLBH_UX_BIT])
            p.page_fault = 1'b1;
         else if (!(lo[ifetch_pkg::TLBL_V_BIT] &&
                    lo[31:ifetch_pkg::PAGE_SHIFT] == va[31:ifetch_pkg::PAGE_SHIFT]))
            p.tlb_miss = 1'b1;
      end
      p.insn = image[pa[ifetch_pkg::IMAGE_WORDS_LOG2+1:2]];
      return p;
   endfunction

   task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_response(ifetch_pkg::fetch_rsp_t got);
      ifetch_pkg::fetch_rsp_t exp;
      // After a flush exactly the words already in memory precede the target
      if (resync) begin
         if (got.vaddr === flush_target) begin
            assert (old_allowed == 0) else begin
               errors++;
               $display("Response held in memory at the flush was lost before vaddr %h at %0t",
                        got.vaddr, $time);
            end
            resync = 1'b0;
            exp_vaddr = flush_target;
         end else begin
            assert (old_allowed > 0) else begin
               errors++;
               $display("Response for vaddr %h at %0t came from a command cancelled by flush",
                        got.vaddr, $time);
            end
            old_allowed--;
         end
      end
      exp = expected_rsp(exp_vaddr);
      check_field("rsp.vaddr", got.vaddr, exp.vaddr);
      check_field("rsp.insn", got.insn, exp.insn);
      check_field("rsp.tlb_miss", {31'b0, got.tlb_miss}, {31'b0, exp.tlb_miss});
      check_field("rsp.page_fault", {31'b0, got.page_fault}, {31'b0, exp.page_fault});
      exp_vaddr = exp_vaddr + 32'd4;
   endtask

   // Responses sampled mid-cycle and transferred on the next edge
   always @(negedge clk) begin
      if (rst_n && flush_ack)
         ack_seen = 1'b1;
      if (rst_n && rsp_valid && rsp_ready) begin
         check_response(rsp);
         rsp_count++;
      end
   end

   task automatic finish_run(logic timed_out);
      int prop_errors;
      prop_errors = ifetch_top_i.ifetch_properties_i.fail_count;
      $display("Errors: %0d scoreboard, %0d assertion, %0d responses checked",
               errors, prop_errors, rsp_count);
      if (errors == 0 && prop_errors == 0 && !timed_out)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles > MAX_CYCLES) begin
         $display("Timeout: run did not complete within %0d cycles", MAX_CYCLES);
         finish_run(1'b1);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   // One clock with inputs changed 1 ns after the edge
   task automatic step();
      @(posedge clk);
      #1;
      if (random_ready) begin
         lcg_state = lcg_next(lcg_state);
         rsp_ready = (lcg_state[31:30] != 2'b00);
      end
   endtask

   task automatic wait_responses(int n);
      int target;
      target = rsp_count + n;
      while (rsp_count < target)
         step();
   endtask

   // Pipeline three deep so four idle cycles mean empty
   task automatic drain();
      int quiet;
      quiet = 0;
      fetch_en = 1'b0;
      random_ready = 1'b0;
      rsp_ready = 1'b1;
      while (quiet < 4) begin
         step();
         quiet = rsp_valid ? 0 : quiet + 1;
      end
   endtask

   task automatic redirect(ifetch_pkg::vaddr_t addr, int old_words);
      flush_target = addr;
      old_allowed = old_words;
      resync = 1'b1;
      ack_seen = 1'b0;
      flush_addr = addr;
      flush_req = 1'b1;
      while (!ack_seen)
         step();
      flush_req = 1'b0;
   endtask

   task automatic tlb_write(ifetch_pkg::tlb_idx_t idx, logic sel_hi, ifetch_pkg::tlb_word_t data);
      tlb_acc.idx = idx;
      tlb_acc.sel_hi = sel_hi;
      tlb_acc.wdata = data;
      tlb_acc.we = 1'b1;
      if (sel_hi)
         model_hi[idx] = data;
      else
         model_lo[idx] = data;
      step();
      tlb_acc.we = 1'b0;
   endtask

   task automatic map_page(ifetch_pkg::vpn_t vpn, ifetch_pkg::ppn_t ppn,
                           logic v, logic rx, logic ux);
      ifetch_pkg::tlb_word_t lo;
      ifetch_pkg::tlb_word_t hi;
      lo = {vpn, 13'b0};
      lo[ifetch_pkg::TLBL_V_BIT] = v;
      hi = {ppn, 13'b0};
      hi[ifetch_pkg::TLBH_RX_BIT] = rx;
      hi[ifetch_pkg::TLBH_UX_BIT] = ux;
      tlb_write(vpn[ifetch_pkg::TLB_SETS_LOG2-1:0], 1'b0, lo);
      tlb_write(vpn[ifetch_pkg::TLB_SETS_LOG2-1:0], 1'b1, hi);
   endtask

   // Both halves of one set with data one cycle after the access
   task automatic readback_entry(ifetch_pkg::tlb_idx_t idx);
      tlb_acc.idx = idx;
      tlb_acc.we = 1'b0;
      tlb_acc.sel_hi = 1'b0;
      step();
      check_field("tlb_rdata", tlb_rdata, model_lo[idx]);
      tlb_acc.sel_hi = 1'b1;
      step();
      check_field("tlb_rdata", tlb_rdata, model_hi[idx]);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      rst_n = 1'b0;
      fetch_en = 1'b0;
      psr = '0;
      flush_req = 1'b0;
      flush_addr = '0;
      tlb_acc = '0;
      rsp_ready = 1'b0;
      random_ready = 1'b0;
      lcg_state = 32'hd287;
      errors = 0;
      rsp_count = 0;
      exp_vaddr = ifetch_pkg::RESET_PC;
      flush_target = '0;
      resync = 1'b0;
      old_allowed = 0;
      ack_seen = 1'b0;
      for (int i = 0; i < NSETS; i++) begin
         model_lo[i] = '0;
         model_hi[i] = '0;
      end
      $readmemh("bench/insn_image.hex", image);
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Sequential stream with translation off under random back-pressure
      fetch_en = 1'b1;
      random_ready = 1'b1;
      wait_responses(N_SEQ);

      // Fill every stage and flush with memory holding one word
      random_ready = 1'b0;
      rsp_ready = 1'b0;
      while (!rsp_valid)
         step();
      step();
      step();
      redirect(32'h0000_0040, 1);
      random_ready = 1'b1;
      wait_responses(N_POST_FLUSH);
      drain();

      // TLB programming and software read-back
      map_page(19'd5, 19'h40, 1'b1, 1'b1, 1'b1);
      map_page(19'd7, 19'd9, 1'b1, 1'b0, 1'b1);
      map_page(19'd8, 19'd3, 1'b0, 1'b0, 1'b1);
      for (int i = 40; i < 44; i++) begin
         lcg_state = lcg_next(lcg_state);
         tlb_write(i[5:0], 1'b0, lcg_state);
         lcg_state = lcg_next(lcg_state);
         tlb_write(i[5:0], 1'b1, lcg_state);
      end
      readback_entry(6'd5);
      readback_entry(6'd7);
      readback_entry(6'd8);
      for (int i = 40; i < 44; i++)
         readback_entry(i[5:0]);

      // User-mode sequential run through a mapped page
      psr.imme = 1'b1;
      psr.rm = 1'b0;
      fetch_en = 1'b1;
      random_ready = 1'b1;
      redirect({19'd5, 13'h0100}, 0);
      wait_responses(N_MAPPED);
      drain();

      // Single fetches for fault, supervisor hit, VPN mismatch and invalid entry
      psr.rm = 1'b1;
      redirect({19'd7, 13'h0000}, 0);
      wait_responses(1);
      redirect({19'd5, 13'h0024}, 0);
      wait_responses(1);
      psr.rm = 1'b0;
      redirect({19'd71, 13'h0008}, 0);
      wait_responses(1);
      redirect({19'd8, 13'h0010}, 0);
      wait_responses(1);
      drain();

      finish_run(1'b0);
   end

endmodule

/* bench/insn_image.hex */
// One 32-bit instruction word per line, word addresses 0 to 31
// Pattern: {address, a5, inverted address, 13}
00A5FF13
01A5FE13
02A5FD13
03A5FC13
04A5FB13
05A5FA13
06A5F913
07A5F813
08A5F713
09A5F613
0AA5F513
0BA5F413
0CA5F313
0DA5F213
0EA5F113
0FA5F013
10A5EF13
11A5EE13
12A5ED13
13A5EC13
14A5EB13
15A5EA13
16A5E913
17A5E813
18A5E713
19A5E613
1AA5E513
1BA5E413
1CA5E313
1DA5E213
1EA5E113
1FA5E013

/* project.f */
hw/ifetch_pkg.sv
hw/fetch_addr_gen.sv
hw/immu_tlb.sv
hw/immu.sv
hw/insn_mem.sv
hw/ifetch_top.sv
bench/ifetch_properties.sv
bench/ifetch_tb.sv

/* Bender.yml */
package:
  name: ifetch

sources:
  - hw/ifetch_pkg.sv
  - hw/fetch_addr_gen.sv
  - hw/immu_tlb.sv
  - hw/immu.sv
  - hw/insn_mem.sv
  - hw/ifetch_top.sv
  - target: test
    files:
      - bench/ifetch_properties.sv
      - bench/ifetch_tb.sv
